/* all.f */
rtl/core_pkg.sv
rtl/fetch.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/decode.sv
rtl/execute.sv
rtl/mem_wb.sv
rtl/core.sv
verif/tb_memory.sv
verif/tb_core.sv

/* verif/tb_core.sv */
`timescale 1ns/1ns

module tb_core;

	localparam logic [31:0] RESET_PC = 32'h0000_0200;
	localparam int N_TESTS = 6;

	logic        clk;
	logic        rst;
	logic [31:0] read_instruction;
	logic [31:0] read_data;
	logic [31:0] instruction_address;
	logic [31:0] data_address;
	logic [31:0] write_data;
	logic        mem_write;
	logic        mem_read;

	// expected store stream in execution order, addresses from 0x40 upward
	logic [31:0] exp_data [0:63];
	int          exp_test [0:63];
	logic [31:0] exp_addr_now;
	logic [31:0] exp_data_now;
	logic [31:0] regs [0:31];
	logic [31:0] words [0:7];
	logic [31:0] seed;
	logic        ready = 1'b0;
	string       names [0:N_TESTS-1] = '{"reset", "alu_chain", "load_use",
		"subword_load", "branch", "jal_jr"};
	int          test_errors [0:N_TESTS-1] = '{default: 0};
	int          tests_passed = 0;
	int          store_idx = 0;
	int          n_exp = 0;
	int          errors = 0;

	core #(
		.RESET_PC(RESET_PC)
	) i_core (
		.i_clk(clk),
		.i_rst(rst),
		.i_read_instruction(read_instruction),
		.i_read_data(read_data),
		.o_instruction_address(instruction_address),
		.o_data_address(data_address),
		.o_write_data(write_data),
		.o_mem_write(mem_write),
		.o_mem_read(mem_read)
	);

	tb_memory #(
		.RESET_PC(RESET_PC)
	) u_mem (
		.i_clk(clk),
		.i_instr_addr(instruction_address),
		.o_instr(read_instruction),
		.i_data_addr(data_address),
		.i_write_data(write_data),
		.i_mem_write(mem_write),
		.o_read_data(read_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic expect_store(input int t, input logic [31:0] data);
		exp_data[n_exp] = data;
		exp_test[n_exp] = t;
		n_exp++;
	endtask

	task automatic build_expected();
		logic [31:0] b;
		expect_store(0, 32'd0);
		regs[1] = words[0];
		regs[2] = words[1];
		regs[3] = regs[1] + regs[2];
		regs[4] = regs[3] - regs[1];
		regs[5] = regs[4] & regs[2];
		regs[6] = regs[5] | regs[3];
		regs[7] = regs[6] ^ regs[4];
		regs[8] = ~(regs[7] | regs[5]);
		regs[9] = 32'($signed(regs[8]) < $signed(regs[1]));
		regs[10] = 32'(regs[1] < regs[8]);
		regs[11] = regs[8] << 3;
		regs[12] = regs[8] >> 7;
		regs[13] = $unsigned($signed(regs[8]) >>> 5);
		regs[14] = regs[13] + 32'hffff_fb2e;
		regs[15] = regs[14] & 32'h0000_f0f0;
		regs[16] = regs[15] | 32'h0000_8421;
		regs[17] = regs[16] ^ 32'h0000_ffff;
		regs[18] = 32'($signed(regs[14]) < -5);
		regs[19] = 32'hbeef_0000;
		for (int r = 19; r >= 3; r--) begin
			expect_store(1, regs[r]);
		end
		expect_store(2, words[3] + regs[1]);
		expect_store(2, words[4] + words[3] + regs[1]);
		expect_store(2, words[5] + words[4] + words[3] + regs[1]);
		// little endian, byte k in bits 8k+7:8k
		for (int k = 0; k < 4; k++) begin
			b = words[6] >> (8 * k);
			regs[20 + k] = {{24{b[7]}}, b[7:0]};
			regs[24 + k] = {24'h0, b[7:0]};
		end
		for (int k = 0; k < 2; k++) begin
			b = words[6] >> (16 * k);
			regs[28 + k] = {{16{b[15]}}, b[15:0]};
			regs[30 + k] = {16'h0, b[15:0]};
		end
		for (int r = 20; r <= 31; r++) begin
			expect_store(3, regs[r]);
		end
		// delay slots always, fall-through only when not taken
		expect_store(4, regs[2]);
		expect_store(4, regs[4]);
		expect_store(4, regs[5]);
		expect_store(4, regs[6]);
		expect_store(4, regs[8]);
		expect_store(4, regs[9]);
		expect_store(5, regs[3]);
		expect_store(5, u_mem.jal_addr + 32'd8);
		expect_store(5, regs[4]);
		expect_store(5, regs[5]);
	endtask

	task automatic count_error(input int t);
		errors++;
		test_errors[t]++;
	endtask

	task automatic store_failed();
		if (store_idx >= n_exp) begin
			$display("unexpected store of %h to %h after the last expected store",
				write_data, data_address);
			count_error(N_TESTS - 1);
		end else begin
			if (data_address != exp_addr_now) begin
				$display("CHECK FAILED %s store %0d address: expected %h actual %h",
					names[exp_test[store_idx]], store_idx, exp_addr_now, data_address);
			end
			if (write_data != exp_data_now) begin
				$display("CHECK FAILED %s store %0d data: expected %h actual %h",
					names[exp_test[store_idx]], store_idx, exp_data_now, write_data);
			end
			count_error(exp_test[store_idx]);
		end
	endtask

	task automatic finish_test(input int t);
		if (test_errors[t] == 0) begin
			tests_passed++;
			$display("test %s: passed", names[t]);
		end else begin
			$display("test %s: failed with %0d errors", names[t], test_errors[t]);
		end
	endtask

	assign exp_addr_now = 32'h40 + 32'(store_idx * 4);
	assign exp_data_now = exp_data[store_idx];

	a_store: assert property (@(negedge clk) disable iff (rst)
		mem_write |-> store_idx < n_exp && data_address == exp_addr_now &&
			write_data == exp_data_now)
	else begin
		store_failed();
	end

	// data port idle in reset and up to the first store
	a_quiet: assert property (@(negedge clk)
		store_idx == 0 |-> !mem_read && !(rst && mem_write))
	else begin
		$display("data memory strobe active before the first store");
		count_error(0);
	end

	a_reset_pc: assert property (@(negedge clk)
		$fell(rst) |-> instruction_address == RESET_PC)
	else begin
		$display("CHECK FAILED reset first fetch: expected %h actual %h",
			RESET_PC, instruction_address);
		count_error(0);
	end

	always @(posedge clk) begin
		if (!rst && mem_write && store_idx < n_exp) begin
			if (store_idx + 1 == n_exp || exp_test[store_idx + 1] != exp_test[store_idx]) begin
				finish_test(exp_test[store_idx]);
			end
			store_idx <= store_idx + 1;
		end
	end

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	initial begin
		rst = 1'b1;
		seed = 32'ha336_f8e4;
		@(posedge clk);
		#1;
		for (int i = 0; i < 8; i++) begin
			seed = lcg_next(seed);
			words[i] = seed;
			u_mem.dmem[i] = seed;
		end
		build_expected();
		ready = 1'b1;
		@(posedge clk);
		#1;
		rst = 1'b0;
		wait (store_idx == n_exp);
		// room for a stray store after the last one
		repeat (20) @(posedge clk);
		$display("tests passed %0d of %0d, stores checked %0d of %0d, errors %0d",
			tests_passed, N_TESTS, store_idx, n_exp, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// 40 cycles per expected store plus 100
	initial begin
		wait (ready);
		repeat (40 * n_exp + 100) @(posedge clk);
		$display("timeout after %0d cycles with %0d of %0d expected stores seen",
			40 * n_exp + 100, store_idx, n_exp);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* verif/tb_memory.sv */
`timescale 1ns/1ns

module tb_memory #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        i_clk,
	input  logic [31:0] i_instr_addr,
	output logic [31:0] o_instr,
	input  logic [31:0] i_data_addr,
	input  logic [31:0] i_write_data,
	input  logic        i_mem_write,
	output logic [31:0] o_read_data
);

	logic [31:0] rom [0:127];
	logic [31:0] dmem [0:63];
	logic [31:0] rom_idx;
	logic [31:0] jal_addr;
	int          n_instr;
	int          slot;

	function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	// operand order as in assembly, op rt, imm(rs)
	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [5:0] op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	task automatic emit(input logic [31:0] word);
		rom[n_instr] = word;
		n_instr++;
	endtask

	// result words start at byte 0x40
	task automatic store_at(input logic [4:0] rt, input int k);
		emit(itype(core_pkg::OP_SW, rt, 5'd0, 16'(32'h40 + 4 * k)));
	endtask

	task automatic store_next(input logic [4:0] rt);
		store_at(rt, slot);
		slot++;
	endtask

	initial begin
		n_instr = 0;
		slot = 0;
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'hd00d_0000 | 32'(i << 2);
		end
		// first data access of the run is a store
		store_next(5'd0);
		// alu chain on words 0 and 1
		emit(itype(core_pkg::OP_LW, 5'd1, 5'd0, 16'd0));
		emit(itype(core_pkg::OP_LW, 5'd2, 5'd0, 16'd4));
		emit(rtype(core_pkg::F_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
		emit(rtype(core_pkg::F_SUBU, 5'd4, 5'd3, 5'd1, 5'd0));
		emit(rtype(core_pkg::F_AND, 5'd5, 5'd4, 5'd2, 5'd0));
		emit(rtype(core_pkg::F_OR, 5'd6, 5'd5, 5'd3, 5'd0));
		emit(rtype(core_pkg::F_XOR, 5'd7, 5'd6, 5'd4, 5'd0));
		emit(rtype(core_pkg::F_NOR, 5'd8, 5'd7, 5'd5, 5'd0));
		emit(rtype(core_pkg::F_SLT, 5'd9, 5'd8, 5'd1, 5'd0));
		emit(rtype(core_pkg::F_SLTU, 5'd10, 5'd1, 5'd8, 5'd0));
		emit(rtype(core_pkg::F_SLL, 5'd11, 5'd0, 5'd8, 5'd3));
		emit(rtype(core_pkg::F_SRL, 5'd12, 5'd0, 5'd8, 5'd7));
		emit(rtype(core_pkg::F_SRA, 5'd13, 5'd0, 5'd8, 5'd5));
		emit(itype(core_pkg::OP_ADDIU, 5'd14, 5'd13, 16'hfb2e));
		emit(itype(core_pkg::OP_ANDI, 5'd15, 5'd14, 16'hf0f0));
		emit(itype(core_pkg::OP_ORI, 5'd16, 5'd15, 16'h8421));
		emit(itype(core_pkg::OP_XORI, 5'd17, 5'd16, 16'hffff));
		emit(itype(core_pkg::OP_SLTI, 5'd18, 5'd14, 16'hfffb));
		emit(itype(core_pkg::OP_LUI, 5'd19, 5'd0, 16'hbeef));
		// newest first, so the first sw needs its data forwarded
		for (int r = 19; r >= 3; r--) begin
			store_next(5'(r));
		end
		// load-use pairs on words 3 to 5
		emit(itype(core_pkg::OP_LW, 5'd20, 5'd0, 16'd12));
		emit(rtype(core_pkg::F_ADDU, 5'd21, 5'd20, 5'd1, 5'd0));
		emit(itype(core_pkg::OP_LW, 5'd22, 5'd0, 16'd16));
		emit(rtype(core_pkg::F_ADDU, 5'd23, 5'd22, 5'd21, 5'd0));
		emit(itype(core_pkg::OP_LW, 5'd24, 5'd0, 16'd20));
		emit(rtype(core_pkg::F_ADDU, 5'd25, 5'd24, 5'd23, 5'd0));
		store_next(5'd21);
		store_next(5'd23);
		store_next(5'd25);
		// sub-word loads of word 6 at every legal offset
		for (int k = 0; k < 4; k++) begin
			emit(itype(core_pkg::OP_LB, 5'(20 + k), 5'd0, 16'(24 + k)));
			emit(itype(core_pkg::OP_LBU, 5'(24 + k), 5'd0, 16'(24 + k)));
		end
		for (int k = 0; k < 2; k++) begin
			emit(itype(core_pkg::OP_LH, 5'(28 + k), 5'd0, 16'(24 + 2 * k)));
			emit(itype(core_pkg::OP_LHU, 5'(30 + k), 5'd0, 16'(24 + 2 * k)));
		end
		for (int r = 20; r <= 31; r++) begin
			store_next(5'(r));
		end
		// beq taken while r26 is still in EX, skipped store goes to 0xfc
		emit(rtype(core_pkg::F_ADDU, 5'd26, 5'd1, 5'd0, 5'd0));
		emit(itype(core_pkg::OP_BEQ, 5'd1, 5'd26, 16'd2));
		store_next(5'd2);
		emit(itype(core_pkg::OP_SW, 5'd3, 5'd0, 16'h00fc));
		// beq not taken
		emit(itype(core_pkg::OP_BEQ, 5'd0, 5'd19, 16'd2));
		store_next(5'd4);
		store_next(5'd5);
		// bne taken
		emit(itype(core_pkg::OP_BNE, 5'd0, 5'd19, 16'd2));
		store_next(5'd6);
		emit(itype(core_pkg::OP_SW, 5'd7, 5'd0, 16'h00fc));
		// bne not taken on a register just loaded
		emit(itype(core_pkg::OP_LW, 5'd27, 5'd0, 16'd28));
		emit(itype(core_pkg::OP_BNE, 5'd27, 5'd27, 16'd2));
		store_next(5'd8);
		store_next(5'd9);
		// jal to the subroutine five words on, stores follow execution order
		jal_addr = RESET_PC + 32'(n_instr * 4);
		emit(jtype(core_pkg::OP_JAL, jal_addr + 32'd20));
		store_at(5'd3, slot);
		store_at(5'd5, slot + 3);
		emit(jtype(core_pkg::OP_J, RESET_PC + 32'(n_instr * 4)));
		emit(32'h0);
		store_at(5'd31, slot + 1);
		emit(rtype(core_pkg::F_JR, 5'd0, 5'd31, 5'd0, 5'd0));
		store_at(5'd4, slot + 2);
	end

	assign rom_idx = (i_instr_addr - RESET_PC) >> 2;
	// past the program only nops
	assign o_instr = (rom_idx < 32'(n_instr)) ? rom[rom_idx] : 32'h0;
	assign o_read_data = dmem[i_data_addr[7:2]];

	always @(posedge i_clk) begin
		if (i_mem_write) begin
			dmem[i_data_addr[7:2]] <= i_write_data;
		end
	end

endmodule

/* rtl/core.sv */
`timescale 1ns/1ns

module core #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [31:0] i_read_instruction,
	input  logic [31:0] i_read_data,
	output logic [31:0] o_instruction_address,
	output logic [31:0] o_data_address,
	output logic [31:0] o_write_data,
	output logic        o_mem_write,
	output logic        o_mem_read
);

	// fetch to decode
	logic [31:0] if_pc4;
	logic [31:0] if_instr;
	// decode back to fetch
	logic        id_redirect;
	logic [31:0] id_target;
	logic        id_stall;
	// writeback
	logic        wb_we;
	logic [4:0]  wb_dst;
	logic [31:0] wb_data;

	core_pkg::id_ex_t  id_ex;
	core_pkg::ex_mem_t ex_mem;

	fetch #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_instr(i_read_instruction),
		.i_stall(id_stall),
		.i_redirect(id_redirect),
		.i_target(id_target),
		.o_pc(o_instruction_address),
		.o_pc4(if_pc4),
		.o_instr(if_instr)
	);

	decode u_decode (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_pc4(if_pc4),
		.i_instr(if_instr),
		.i_wb_we(wb_we),
		.i_wb_dst(wb_dst),
		.i_wb_data(wb_data),
		.i_mem(ex_mem),
		.o_id_ex(id_ex),
		.o_redirect(id_redirect),
		.o_target(id_target),
		.o_stall(id_stall)
	);

	execute u_execute (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_id_ex(id_ex),
		.i_wb_data(wb_data),
		.o_ex_mem(ex_mem)
	);

	mem_wb u_mem_wb (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_ex_mem(ex_mem),
		.i_read_data(i_read_data),
		.o_data_address(o_data_address),
		.o_write_data(o_write_data),
		.o_mem_write(o_mem_write),
		.o_mem_read(o_mem_read),
		.o_wb_we(wb_we),
		.o_wb_dst(wb_dst),
		.o_wb_data(wb_data)
	);

endmodule

/* rtl/mem_wb.sv */
`timescale 1ns/1ns

module mem_wb (
	input  logic              i_clk,
	input  logic              i_rst,
	input  core_pkg::ex_mem_t i_ex_mem,
	input  logic [31:0]       i_read_data,
	output logic [31:0]       o_data_address,
	output logic [31:0]       o_write_data,
	output logic              o_mem_write,
	output logic              o_mem_read,
	output logic              o_wb_we,
	output logic [4:0]        o_wb_dst,
	output logic [31:0]       o_wb_data
);

	core_pkg::mem_wb_t r;
	logic [31:0]       shifted;
	logic [15:0]       half;
	logic [31:0]       load_val;

	assign o_data_address = i_ex_mem.alu_res;
	assign o_write_data   = i_ex_mem.store_data;
	assign o_mem_write    = i_ex_mem.mem_write;
	assign o_mem_read     = i_ex_mem.mem_read;

	// MEM/WB
	always_ff @(posedge i_clk) begin
		r.alu_res   <= i_ex_mem.alu_res;
		r.load_raw  <= i_read_data;
		r.offset    <= i_ex_mem.alu_res[1:0];
		r.pc8       <= i_ex_mem.pc8;
		r.dst       <= i_ex_mem.dst;
		r.load_kind <= i_ex_mem.load_kind;
		r.wb_sel    <= i_ex_mem.wb_sel;
		if (i_rst) begin
			r.reg_write <= 1'b0;
		end else begin
			r.reg_write <= i_ex_mem.reg_write;
		end
	end

	// little endian, byte 0 in bits 7:0
	assign shifted = r.load_raw >> {r.offset, 3'b000};
	assign half    = r.offset[1] ? r.load_raw[31:16] : r.load_raw[15:0];

	always_comb begin
		case (r.load_kind)
			core_pkg::LD_HS: load_val = {{16{half[15]}}, half};
			core_pkg::LD_HU: load_val = {16'h0, half};
			core_pkg::LD_BS: load_val = {{24{shifted[7]}}, shifted[7:0]};
			core_pkg::LD_BU: load_val = {24'h0, shifted[7:0]};
			default:         load_val = r.load_raw;
		endcase
	end

	always_comb begin
		case (r.wb_sel)
			core_pkg::WB_LOAD: o_wb_data = load_val;
			core_pkg::WB_PC8:  o_wb_data = r.pc8;
			default:           o_wb_data = r.alu_res;
		endcase
	end

	assign o_wb_we  = r.reg_write;
	assign o_wb_dst = r.dst;

	a_load_align: assert property (@(posedge i_clk) disable iff (i_rst)
		i_ex_mem.mem_read |->
		(i_ex_mem.load_kind == core_pkg::LD_W -> i_ex_mem.alu_res[1:0] == 2'b00) &&
		((i_ex_mem.load_kind == core_pkg::LD_HS || i_ex_mem.load_kind == core_pkg::LD_HU)
			-> i_ex_mem.alu_res[0] == 1'b0));

endmodule

/* rtl/execute.sv */
`timescale 1ns/1ns

module execute (
	input  logic              i_clk,
	input  logic              i_rst,
	input  core_pkg::id_ex_t  i_id_ex,
	input  logic [31:0]       i_wb_data,
	output core_pkg::ex_mem_t o_ex_mem
);

	logic [31:0] mem_res;
	logic [31:0] a;
	logic [31:0] rt_fwd;
	logic [31:0] b;
	logic [31:0] res;

	// the MEM stage is this module's own output register
	assign mem_res = core_pkg::mem_result(o_ex_mem);
	assign a       = core_pkg::fwd_pick(i_id_ex.fwd_a, i_id_ex.rs_val, mem_res, i_wb_data);
	assign rt_fwd  = core_pkg::fwd_pick(i_id_ex.fwd_b, i_id_ex.rt_val, mem_res, i_wb_data);
	assign b       = i_id_ex.alu_src_imm ? i_id_ex.imm : rt_fwd;

	always_comb begin
		case (i_id_ex.alu_op)
			core_pkg::ALU_ADD:  res = a + b;
			core_pkg::ALU_SUB:  res = a - b;
			core_pkg::ALU_AND:  res = a & b;
			core_pkg::ALU_OR:   res = a | b;
			core_pkg::ALU_XOR:  res = a ^ b;
			core_pkg::ALU_NOR:  res = ~(a | b);
			core_pkg::ALU_SLT:  res = {31'd0, $signed(a) < $signed(b)};
			core_pkg::ALU_SLTU: res = {31'd0, a < b};
			// shifts work on rt by the shamt field
			core_pkg::ALU_SLL:  res = b << i_id_ex.shamt;
			core_pkg::ALU_SRL:  res = b >> i_id_ex.shamt;
			core_pkg::ALU_SRA:  res = $unsigned($signed(b) >>> i_id_ex.shamt);
			core_pkg::ALU_LUI:  res = {b[15:0], 16'h0};
			default:            res = a + b;
		endcase
	end

	// EX/MEM
	always_ff @(posedge i_clk) begin
		o_ex_mem.alu_res    <= res;
		o_ex_mem.store_data <= rt_fwd;
		o_ex_mem.pc8        <= i_id_ex.pc8;
		o_ex_mem.dst        <= i_id_ex.dst;
		o_ex_mem.load_kind  <= i_id_ex.load_kind;
		o_ex_mem.wb_sel     <= i_id_ex.wb_sel;
		if (i_rst) begin
			o_ex_mem.mem_read  <= 1'b0;
			o_ex_mem.mem_write <= 1'b0;
			o_ex_mem.reg_write <= 1'b0;
		end else begin
			o_ex_mem.mem_read  <= i_id_ex.valid && i_id_ex.mem_read;
			o_ex_mem.mem_write <= i_id_ex.valid && i_id_ex.mem_write;
			o_ex_mem.reg_write <= i_id_ex.valid && i_id_ex.reg_write;
		end
	end

	a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_id_ex.mem_read && i_id_ex.mem_write));

	// a load in MEM is never a forwarding source, the hazard stall covers it
	a_no_load_fwd: assert property (@(posedge i_clk) disable iff (i_rst)
		i_id_ex.valid && o_ex_mem.mem_read |->
		i_id_ex.fwd_a != core_pkg::FWD_MEM && i_id_ex.fwd_b != core_pkg::FWD_MEM);

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ns

module decode (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic [31:0]       i_pc4,
	input  logic [31:0]       i_instr,
	input  logic              i_wb_we,
	input  logic [4:0]        i_wb_dst,
	input  logic [31:0]       i_wb_data,
	input  core_pkg::ex_mem_t i_mem,
	output core_pkg::id_ex_t  o_id_ex,
	output logic              o_redirect,
	output logic [31:0]       o_target,
	output logic              o_stall
);

	core_pkg::opcode_e    op;
	core_pkg::funct_e     funct;
	core_pkg::alu_op_e    alu_op;
	core_pkg::load_kind_e load_kind;
	core_pkg::wb_sel_e    wb_sel;
	core_pkg::fwd_sel_e   fwd_id_a;
	core_pkg::fwd_sel_e   fwd_id_b;
	core_pkg::fwd_sel_e   fwd_ex_a;
	core_pkg::fwd_sel_e   fwd_ex_b;
	logic [4:0]           rs;
	logic [4:0]           rt;
	logic [4:0]           dst;
	logic [31:0]          imm_ext;
	logic [31:0]          rd1;
	logic [31:0]          rd2;
	logic [31:0]          op_a;
	logic [31:0]          op_b;
	logic alu_src_imm, mem_read, mem_write, we, zero_ext;
	logic uses_rs, uses_rt, is_beq, is_bne, is_j, is_jr, taken;

	assign op    = core_pkg::opcode_e'(i_instr[31:26]);
	assign funct = core_pkg::funct_e'(i_instr[5:0]);
	assign rs    = i_instr[25:21];
	assign rt    = i_instr[20:16];
	assign imm_ext = zero_ext ? {16'h0, i_instr[15:0]} : {{16{i_instr[15]}}, i_instr[15:0]};

	always_comb begin
		alu_op      = core_pkg::ALU_ADD;
		alu_src_imm = 1'b1;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		load_kind   = core_pkg::LD_W;
		wb_sel      = core_pkg::WB_ALU;
		we          = 1'b0;
		dst         = rt;
		zero_ext    = 1'b0;
		uses_rs     = 1'b1;
		uses_rt     = 1'b0;
		is_beq      = 1'b0;
		is_bne      = 1'b0;
		is_j        = 1'b0;
		is_jr       = 1'b0;
		case (op)
			core_pkg::OP_RTYPE: begin
				alu_src_imm = 1'b0;
				uses_rt     = 1'b1;
				we          = 1'b1;
				dst         = i_instr[15:11];
				case (funct)
					core_pkg::F_SLL:  begin alu_op = core_pkg::ALU_SLL; uses_rs = 1'b0; end
					core_pkg::F_SRL:  begin alu_op = core_pkg::ALU_SRL; uses_rs = 1'b0; end
					core_pkg::F_SRA:  begin alu_op = core_pkg::ALU_SRA; uses_rs = 1'b0; end
					core_pkg::F_JR:   begin is_jr = 1'b1; uses_rt = 1'b0; we = 1'b0; end
					core_pkg::F_ADDU: alu_op = core_pkg::ALU_ADD;
					core_pkg::F_SUBU: alu_op = core_pkg::ALU_SUB;
					core_pkg::F_AND:  alu_op = core_pkg::ALU_AND;
					core_pkg::F_OR:   alu_op = core_pkg::ALU_OR;
					core_pkg::F_XOR:  alu_op = core_pkg::ALU_XOR;
					core_pkg::F_NOR:  alu_op = core_pkg::ALU_NOR;
					core_pkg::F_SLT:  alu_op = core_pkg::ALU_SLT;
					core_pkg::F_SLTU: alu_op = core_pkg::ALU_SLTU;
					default:          we = 1'b0;
				endcase
			end
			core_pkg::OP_J:   begin is_j = 1'b1; uses_rs = 1'b0; end
			core_pkg::OP_JAL: begin
				is_j    = 1'b1;
				uses_rs = 1'b0;
				we      = 1'b1;
				dst     = 5'd31;
				wb_sel  = core_pkg::WB_PC8;
			end
			core_pkg::OP_BEQ:   begin is_beq = 1'b1; uses_rt = 1'b1; end
			core_pkg::OP_BNE:   begin is_bne = 1'b1; uses_rt = 1'b1; end
			core_pkg::OP_ADDIU: we = 1'b1;
			core_pkg::OP_SLTI:  begin alu_op = core_pkg::ALU_SLT; we = 1'b1; end
			core_pkg::OP_ANDI:  begin alu_op = core_pkg::ALU_AND; we = 1'b1; zero_ext = 1'b1; end
			core_pkg::OP_ORI:   begin alu_op = core_pkg::ALU_OR; we = 1'b1; zero_ext = 1'b1; end
			core_pkg::OP_XORI:  begin alu_op = core_pkg::ALU_XOR; we = 1'b1; zero_ext = 1'b1; end
			core_pkg::OP_LUI:   begin alu_op = core_pkg::ALU_LUI; we = 1'b1; uses_rs = 1'b0; end
			core_pkg::OP_LW, core_pkg::OP_LH, core_pkg::OP_LHU,
			core_pkg::OP_LB, core_pkg::OP_LBU: begin
				mem_read = 1'b1;
				wb_sel   = core_pkg::WB_LOAD;
				we       = 1'b1;
				case (op)
					core_pkg::OP_LH:  load_kind = core_pkg::LD_HS;
					core_pkg::OP_LHU: load_kind = core_pkg::LD_HU;
					core_pkg::OP_LB:  load_kind = core_pkg::LD_BS;
					core_pkg::OP_LBU: load_kind = core_pkg::LD_BU;
					default:          load_kind = core_pkg::LD_W;
				endcase
			end
			core_pkg::OP_SW: begin mem_write = 1'b1; uses_rt = 1'b1; end
			default: uses_rs = 1'b0;
		endcase
	end

	regfile u_regfile (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_ra1(rs),
		.i_ra2(rt),
		.i_we(i_wb_we),
		.i_wa(i_wb_dst),
		.i_wd(i_wb_data),
		.o_rd1(rd1),
		.o_rd2(rd2)
	);

	hazard_unit u_hazard_unit (
		.i_rs(rs),
		.i_rt(rt),
		.i_uses_rs(uses_rs),
		.i_uses_rt(uses_rt),
		.i_is_branch(is_beq || is_bne || is_jr),
		.i_ex(o_id_ex),
		.i_mem(i_mem),
		.i_wb_we(i_wb_we),
		.i_wb_dst(i_wb_dst),
		.o_stall(o_stall),
		.o_fwd_id_a(fwd_id_a),
		.o_fwd_id_b(fwd_id_b),
		.o_fwd_ex_a(fwd_ex_a),
		.o_fwd_ex_b(fwd_ex_b)
	);

	// branch and jr operands, never a load in MEM since that stalls
	assign op_a = core_pkg::fwd_pick(fwd_id_a, rd1, core_pkg::mem_result(i_mem), i_wb_data);
	assign op_b = core_pkg::fwd_pick(fwd_id_b, rd2, core_pkg::mem_result(i_mem), i_wb_data);

	assign taken = is_j || is_jr || (is_beq && op_a == op_b) || (is_bne && op_a != op_b);
	assign o_redirect = taken && !o_stall;

	always_comb begin
		if (is_jr) begin
			o_target = op_a;
		end else if (is_j) begin
			o_target = {i_pc4[31:28], i_instr[25:0], 2'b00};
		end else begin
			o_target = i_pc4 + {imm_ext[29:0], 2'b00};
		end
	end

	// ID/EX, a stall becomes a bubble
	always_ff @(posedge i_clk) begin
		o_id_ex.pc8         <= i_pc4 + 32'd4;
		o_id_ex.rs_val      <= rd1;
		o_id_ex.rt_val      <= rd2;
		o_id_ex.imm         <= imm_ext;
		o_id_ex.shamt       <= i_instr[10:6];
		o_id_ex.rs          <= rs;
		o_id_ex.rt          <= rt;
		o_id_ex.dst         <= dst;
		o_id_ex.alu_op      <= alu_op;
		o_id_ex.alu_src_imm <= alu_src_imm;
		o_id_ex.load_kind   <= load_kind;
		o_id_ex.wb_sel      <= wb_sel;
		o_id_ex.fwd_a       <= fwd_ex_a;
		o_id_ex.fwd_b       <= fwd_ex_b;
		if (i_rst || o_stall) begin
			o_id_ex.valid     <= 1'b0;
			o_id_ex.mem_read  <= 1'b0;
			o_id_ex.mem_write <= 1'b0;
			o_id_ex.reg_write <= 1'b0;
		end else begin
			o_id_ex.valid     <= 1'b1;
			o_id_ex.mem_read  <= mem_read;
			o_id_ex.mem_write <= mem_write;
			o_id_ex.reg_write <= we && (dst != 5'd0);
		end
	end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
	input  logic [4:0]         i_rs,
	input  logic [4:0]         i_rt,
	input  logic               i_uses_rs,
	input  logic               i_uses_rt,
	input  logic               i_is_branch,
	input  core_pkg::id_ex_t   i_ex,
	input  core_pkg::ex_mem_t  i_mem,
	input  logic               i_wb_we,
	input  logic [4:0]         i_wb_dst,
	output logic               o_stall,
	output core_pkg::fwd_sel_e o_fwd_id_a,
	output core_pkg::fwd_sel_e o_fwd_id_b,
	output core_pkg::fwd_sel_e o_fwd_ex_a,
	output core_pkg::fwd_sel_e o_fwd_ex_b
);

	logic ex_hit_rs;
	logic ex_hit_rt;
	logic mem_hit_rs;
	logic mem_hit_rt;
	logic wb_hit_rs;
	logic wb_hit_rt;
	logic load_use;
	logic branch_wait;

	// a source hits a stage when it is read, nonzero and written there
	assign ex_hit_rs  = i_uses_rs && (i_rs != 5'd0) && i_ex.reg_write && (i_ex.dst == i_rs);
	assign ex_hit_rt  = i_uses_rt && (i_rt != 5'd0) && i_ex.reg_write && (i_ex.dst == i_rt);
	assign mem_hit_rs = i_uses_rs && (i_rs != 5'd0) && i_mem.reg_write && (i_mem.dst == i_rs);
	assign mem_hit_rt = i_uses_rt && (i_rt != 5'd0) && i_mem.reg_write && (i_mem.dst == i_rt);
	assign wb_hit_rs  = i_uses_rs && (i_rs != 5'd0) && i_wb_we && (i_wb_dst == i_rs);
	assign wb_hit_rt  = i_uses_rt && (i_rt != 5'd0) && i_wb_we && (i_wb_dst == i_rt);

	assign load_use    = i_ex.mem_read && (ex_hit_rs || ex_hit_rt);
	// branches compare in decode, so any result in EX or a load in MEM comes too late
	assign branch_wait = i_is_branch &&
		(ex_hit_rs || ex_hit_rt || (i_mem.mem_read && (mem_hit_rs || mem_hit_rt)));
	assign o_stall     = load_use || branch_wait;

	always_comb begin
		o_fwd_id_a = core_pkg::FWD_REG;
		o_fwd_id_b = core_pkg::FWD_REG;
		o_fwd_ex_a = core_pkg::FWD_REG;
		o_fwd_ex_b = core_pkg::FWD_REG;
		// branch and jr operands, MEM before WB
		if (mem_hit_rs) begin
			o_fwd_id_a = core_pkg::FWD_MEM;
		end else if (wb_hit_rs) begin
			o_fwd_id_a = core_pkg::FWD_WB;
		end
		if (mem_hit_rt) begin
			o_fwd_id_b = core_pkg::FWD_MEM;
		end else if (wb_hit_rt) begin
			o_fwd_id_b = core_pkg::FWD_WB;
		end
		// used a cycle later, when EX has moved to MEM and MEM to WB
		if (ex_hit_rs) begin
			o_fwd_ex_a = core_pkg::FWD_MEM;
		end else if (mem_hit_rs) begin
			o_fwd_ex_a = core_pkg::FWD_WB;
		end
		if (ex_hit_rt) begin
			o_fwd_ex_b = core_pkg::FWD_MEM;
		end else if (mem_hit_rt) begin
			o_fwd_ex_b = core_pkg::FWD_WB;
		end
	end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ns

module regfile (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [4:0]  i_ra1,
	input  logic [4:0]  i_ra2,
	input  logic        i_we,
	input  logic [4:0]  i_wa,
	input  logic [31:0] i_wd,
	output logic [31:0] o_rd1,
	output logic [31:0] o_rd2
);

	logic [31:0] regs [0:31];
	logic        wr_en;

	// r0 never written
	assign wr_en = i_we && !i_rst && (i_wa != 5'd0);

	// r0 keeps the zero it gets in reset
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			regs[0] <= 32'd0;
		end else if (wr_en) begin
			regs[i_wa] <= i_wd;
		end
	end

	// writeback in the same cycle goes straight to the read
	assign o_rd1 = (wr_en && i_wa == i_ra1) ? i_wd : regs[i_ra1];
	assign o_rd2 = (wr_en && i_wa == i_ra2) ? i_wd : regs[i_ra2];

	a_r0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_ra1 == 5'd0 |-> o_rd1 == 32'd0) and (i_ra2 == 5'd0 |-> o_rd2 == 32'd0));

endmodule

/* rtl/fetch.sv */
`timescale 1ns/1ns

module fetch #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [31:0] i_instr,
	input  logic        i_stall,
	input  logic        i_redirect,
	input  logic [31:0] i_target,
	output logic [31:0] o_pc,
	output logic [31:0] o_pc4,
	output logic [31:0] o_instr
);

	logic [31:0] pc;
	logic [31:0] pc_plus4;

	assign o_pc = pc;
	assign pc_plus4 = pc + 32'd4;

	// redirect lands one cycle after the branch, so the delay slot is already fetched
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pc <= RESET_PC;
		end else if (!i_stall) begin
			pc <= i_redirect ? i_target : pc_plus4;
		end
	end

	// IF/ID, instruction clears to a nop
	always_ff @(posedge i_clk) begin
		if (!i_stall) begin
			o_pc4 <= pc_plus4;
		end
		if (i_rst) begin
			o_instr <= '0;
		end else if (!i_stall) begin
			o_instr <= i_instr;
		end
	end

	// jr targets come from registers, so check every pc
	a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) pc[1:0] == 2'b00);

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LB    = 6'h20,
		OP_LH    = 6'h21,
		OP_LW    = 6'h23,
		OP_LBU   = 6'h24,
		OP_LHU   = 6'h25,
		OP_SW    = 6'h2b
	} opcode_e;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [2:0] {LD_W, LD_HS, LD_HU, LD_BS, LD_BU} load_kind_e;

	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC8} wb_sel_e;

	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc8;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [31:0] imm;
		logic [4:0]  shamt;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dst;
		alu_op_e     alu_op;
		logic        alu_src_imm;
		logic        mem_read;
		logic        mem_write;
		load_kind_e  load_kind;
		wb_sel_e     wb_sel;
		logic        reg_write;
		// operand sources for execute, chosen while in decode
		fwd_sel_e    fwd_a;
		fwd_sel_e    fwd_b;
	} id_ex_t;

	typedef struct packed {
		logic [31:0] alu_res;
		logic [31:0] store_data;
		logic [31:0] pc8;
		logic [4:0]  dst;
		logic        mem_read;
		logic        mem_write;
		load_kind_e  load_kind;
		wb_sel_e     wb_sel;
		logic        reg_write;
	} ex_mem_t;

	typedef struct packed {
		logic [31:0] alu_res;
		logic [31:0] load_raw;
		logic [1:0]  offset;
		logic [31:0] pc8;
		logic [4:0]  dst;
		load_kind_e  load_kind;
		wb_sel_e     wb_sel;
		logic        reg_write;
	} mem_wb_t;

	// value an instruction in MEM will write back, loads excluded
	function automatic logic [31:0] mem_result(input ex_mem_t m);
		return (m.wb_sel == WB_PC8) ? m.pc8 : m.alu_res;
	endfunction

	function automatic logic [31:0] fwd_pick(input fwd_sel_e sel, input logic [31:0] reg_val,
			input logic [31:0] mem_val, input logic [31:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

endpackage
